// ==== dv/vm_tb_checks.svh ====
`ifndef VM_TB_CHECKS_SVH
`define VM_TB_CHECKS_SVH

// money value of a coin mask, from the coin table
function automatic total_t coins_worth(input coin_mask_t mask);
    int sum;
    sum = 0;
    for (int i = 0; i < K_NUM_COINS; i++) begin
        sum += mask[i] ? int'(K_COIN_VALUE[i]) : 0;
    end
    return total_t'(sum);
endfunction

// largest coin first, taken while the remainder still covers it
function automatic coin_mask_t greedy_change(input total_t amount);
    coin_mask_t pick;
    int         left;
    pick = '0;
    left = int'(amount);
    for (int i = K_NUM_COINS - 1; i >= 0; i--) begin
        if (left >= int'(K_COIN_VALUE[i])) begin
            pick[i] = 1'b1;
            left -= int'(K_COIN_VALUE[i]);
        end
    end
    return pick;
endfunction

function automatic item_mask_t items_affordable(input total_t amount);
    item_mask_t ok;
    for (int j = 0; j < K_NUM_ITEMS; j++) begin
        ok[j] = (K_ITEM_PRICE[j] <= amount);
    end
    return ok;
endfunction

// lowest set select bit, -1 when nothing is selected
function automatic int lowest_item(input item_mask_t sel);
    for (int j = 0; j < K_NUM_ITEMS; j++) begin
        if (sel[j]) begin
            return j;
        end
    end
    return -1;
endfunction

task automatic check_total(input string name, input total_t exp, input total_t act,
                           inout int errs);
    if (act !== exp) begin
        $display("Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
        errs++;
    end
endtask

task automatic check_items(input string name, input item_mask_t exp, input item_mask_t act,
                           inout int errs);
    if (act !== exp) begin
        $display("Error at %0t: %s expected %b, got %b", $time, name, exp, act);
        errs++;
    end
endtask

task automatic check_coins(input string name, input coin_mask_t exp, input coin_mask_t act,
                           inout int errs);
    if (act !== exp) begin
        $display("Error at %0t: %s expected %b, got %b", $time, name, exp, act);
        errs++;
    end
endtask

`endif

// ==== dv/vm_tb.sv ====
`timescale 1ns/1ps

module vm_tb
    import vm_money_pkg::*;
    import vm_ctrl_pkg::*;
();

    localparam int K_RESET_CYCLES = 5;
    localparam int K_COIN_LEN = 12;
    localparam int K_MIX_LEN = 24;
    localparam int K_DIRECTED_LEN = 80;
    localparam int K_NUM_RETURNS = 10;
    // every scripted cycle plus the idle wait and payout of each return
    localparam int K_CYCLE_LIMIT = K_RESET_CYCLES + K_COIN_LEN + K_MIX_LEN + K_DIRECTED_LEN
                                 + K_NUM_RETURNS * (K_WAIT_TIME + 20);

    logic       clk;
    logic       reset;
    coin_mask_t coin_in;
    item_mask_t select_in;
    logic       trigger_in;
    item_mask_t available_item;
    item_mask_t output_item;
    coin_mask_t return_coin;
    total_t     current_total;

    int total_errs = 0;
    int item_errs = 0;
    int coin_errs = 0;
    int sum_errs = 0;
    int start_errs = 0;
    int cycle_count = 0;

    // reference model state that only the compare process updates
    total_t     exp_total;
    total_t     returned_sum;
    coin_mask_t pipe_coin [2];
    item_mask_t pipe_sel [2];

    // per-return bookkeeping of the stimulus
    total_t     start_total;
    total_t     returned_base;
    logic       expect_no_return = 1'b0;

    `include "vm_tb_checks.svh"

    vending_machine dut0 (
        .i_clk            (clk),
        .i_reset          (reset),
        .i_input_coin     (coin_in),
        .i_select_item    (select_in),
        .i_trigger_return (trigger_in),
        .o_available_item (available_item),
        .o_output_item    (output_item),
        .o_return_coin    (return_coin),
        .o_current_total  (current_total)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > K_CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", K_CYCLE_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    // coins and selects act 2 cycles after the input while payouts follow the DUT pulses
    always @(negedge clk) begin
        total_t     prev;
        coin_mask_t coin_now;
        item_mask_t exp_vend;
        coin_mask_t exp_ret;
        int         idx;
        if (reset) begin
            exp_total = '0;
            returned_sum = '0;
            pipe_coin = '{default: '0};
            pipe_sel = '{default: '0};
        end else begin
            prev = exp_total;
            coin_now = pipe_coin[1];
            idx = lowest_item(pipe_sel[1]);
            pipe_coin[1] = pipe_coin[0];
            pipe_sel[1] = pipe_sel[0];
            pipe_coin[0] = coin_in;
            pipe_sel[0] = select_in;
            exp_vend = '0;
            exp_ret = '0;
            if (coin_now != '0) begin
                exp_total = prev + coins_worth(coin_now);
            end else if (idx >= 0 && K_ITEM_PRICE[idx] <= prev) begin
                exp_vend = item_mask_t'(1 << idx);
                exp_total = prev - K_ITEM_PRICE[idx];
            end else if (return_coin != '0 && !expect_no_return) begin
                exp_ret = greedy_change(prev);
                exp_total = prev - coins_worth(exp_ret);
            end
            returned_sum = returned_sum + coins_worth(return_coin);
            check_total("o_current_total", exp_total, current_total, total_errs);
            check_items("o_available_item", items_affordable(exp_total), available_item,
                        item_errs);
            check_items("o_output_item", exp_vend, output_item, item_errs);
            check_coins("o_return_coin", exp_ret, return_coin, coin_errs);
        end
    end

    task automatic drive_cycle(input coin_mask_t coin, input item_mask_t sel, input logic trig);
        @(posedge clk);
        coin_in <= coin;
        select_in <= sel;
        trigger_in <= trig;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            drive_cycle('0, '0, 1'b0);
        end
    endtask

    // let the pipeline drain, then note the balance that has to come back
    task automatic mark_return_start();
        idle_cycles(3);
        start_total = exp_total;
        returned_base = returned_sum;
    endtask

    task automatic finish_return(input total_t added);
        @(negedge clk);
        while (current_total != '0) begin
            @(negedge clk);
        end
        @(posedge clk);
        check_total("returned coins", start_total + added, returned_sum - returned_base,
                    sum_errs);
    endtask

    task automatic wait_first_pulse(input int limit, input string what);
        int waited;
        waited = 0;
        @(negedge clk);
        while (return_coin == '0 && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (return_coin == '0) begin
            $display("%s", what);
            start_errs++;
        end
    endtask

    initial begin
        int pick;
        void'($urandom(32'h1d69));
        reset <= 1'b1;
        coin_in <= '0;
        select_in <= '0;
        trigger_in <= 1'b0;
        repeat (K_RESET_CYCLES) begin
            @(posedge clk);
        end
        reset <= 1'b0;

        // random coins, then the idle timer pays everything back
        repeat (K_COIN_LEN) begin
            drive_cycle(coin_mask_t'($urandom), '0, 1'b0);
        end
        mark_return_start();
        finish_return('0);

        // vends, an unavailable item and a multi-bit select
        drive_cycle(3'b111, '0, 1'b0);
        drive_cycle(3'b111, '0, 1'b0);
        drive_cycle('0, 4'b1000, 1'b0);
        drive_cycle('0, 4'b1000, 1'b0);
        drive_cycle('0, 4'b0110, 1'b0);
        drive_cycle('0, 4'b0001, 1'b0);
        drive_cycle('0, 4'b0100, 1'b0);
        mark_return_start();
        finish_return('0);

        repeat (K_MIX_LEN) begin
            pick = int'($urandom % 32'd4);
            if (pick < 2) begin
                drive_cycle(coin_mask_t'($urandom), '0, 1'b0);
            end else if (pick == 2) begin
                drive_cycle('0, item_mask_t'($urandom), 1'b0);
            end else begin
                idle_cycles(1);
            end
        end
        mark_return_start();
        finish_return('0);

        // held trigger starts the payout well before the timer runs out
        drive_cycle(3'b101, '0, 1'b0);
        mark_return_start();
        repeat (K_TRIGGER_HOLD + 1) begin
            drive_cycle('0, '0, 1'b1);
        end
        drive_cycle('0, '0, 1'b0);
        wait_first_pulse(K_TRIGGER_HOLD + 1, "held return request did not start a return");
        finish_return('0);

        // too short a trigger pulse must not pay anything
        drive_cycle(3'b010, '0, 1'b0);
        mark_return_start();
        expect_no_return = 1'b1;
        repeat (K_TRIGGER_HOLD - 1) begin
            drive_cycle('0, '0, 1'b1);
        end
        idle_cycles(K_TRIGGER_HOLD + 2);
        expect_no_return = 1'b0;
        finish_return('0);

        // a coin during the payout stops it and the rest comes back later
        repeat (5) begin
            drive_cycle(3'b111, '0, 1'b0);
        end
        mark_return_start();
        wait_first_pulse(K_WAIT_TIME + 5, "automatic return did not start after the idle time");
        drive_cycle(3'b001, '0, 1'b0);
        idle_cycles(2);
        expect_no_return = 1'b1;
        idle_cycles(K_WAIT_TIME / 2);
        expect_no_return = 1'b0;
        finish_return(K_COIN_VALUE[0]);

        idle_cycles(2);
        $display("error counts: total %0d, items %0d, coins %0d, sums %0d, starts %0d",
                 total_errs, item_errs, coin_errs, sum_errs, start_errs);
        if (total_errs + item_errs + coin_errs + sum_errs + start_errs == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== rtl/vending_machine.sv ====
`timescale 1ns/1ps

module vending_machine
    import vm_money_pkg::*;
    import vm_ctrl_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_reset,
    input  coin_mask_t i_input_coin,
    input  item_mask_t i_select_item,
    input  logic       i_trigger_return,
    output item_mask_t o_available_item,
    output item_mask_t o_output_item,
    output coin_mask_t o_return_coin,
    output total_t     o_current_total
);

    // decode stage outputs
    vm_event_e  r_event;
    total_t     r_coin_sum;
    item_idx_t  r_select_idx;
    logic       r_trigger_level;

    // execute and result stage links
    logic       vend_valid;
    total_t     vend_price;
    coin_mask_t ret_mask;
    total_t     current_total;

    vm_event_decode u_decode (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_input_coin     (i_input_coin),
        .i_select_item    (i_select_item),
        .i_trigger_return (i_trigger_return),
        .o_event          (r_event),
        .o_coin_sum       (r_coin_sum),
        .o_select_idx     (r_select_idx),
        .o_trigger_level  (r_trigger_level)
    );

    vm_balance u_balance (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_event      (r_event),
        .i_coin_sum   (r_coin_sum),
        .i_vend_valid (vend_valid),
        .i_vend_price (vend_price),
        .i_ret_mask   (ret_mask),
        .o_total      (current_total)
    );

    vm_dispense u_dispense (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_event          (r_event),
        .i_select_idx     (r_select_idx),
        .i_total          (current_total),
        .o_available_item (o_available_item),
        .o_vend_valid     (vend_valid),
        .o_vend_price     (vend_price),
        .o_output_item    (o_output_item)
    );

    vm_return_timer u_return_timer (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_event         (r_event),
        .i_trigger_level (r_trigger_level),
        .i_vend_valid    (vend_valid),
        .i_total         (current_total),
        .o_return_coin   (o_return_coin),
        .o_ret_mask      (ret_mask)
    );

    assign o_current_total = current_total;

endmodule

// ==== rtl/vm_balance.sv ====
`timescale 1ns/1ps

module vm_balance
    import vm_money_pkg::*;
    import vm_ctrl_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_reset,
    input  vm_event_e  i_event,
    input  total_t     i_coin_sum,
    input  logic       i_vend_valid,
    input  total_t     i_vend_price,
    input  coin_mask_t i_ret_mask,
    output total_t     o_total
);

    total_t r_total;
    total_t ret_sum;
    total_t drop;

    assign ret_sum = coin_mask_value(i_ret_mask);

    // amount leaving the machine this cycle, vend before change
    assign drop = i_vend_valid ? i_vend_price : ret_sum;

    // one update per cycle that adds a coin or takes out a vend price or change
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            r_total <= '0;
        end else if (i_event == EV_COIN) begin
            r_total <= r_total + i_coin_sum;
        end else begin
            r_total <= r_total - drop;
        end
    end

    assign o_total = r_total;

    // dispense and the return timer both size their request against this total
    a_no_underflow: assert property (
        @(posedge i_clk) disable iff (i_reset)
        (i_event != EV_COIN) |-> (drop <= r_total)
    );

endmodule

// ==== rtl/vm_ctrl_pkg.sv ====
package vm_ctrl_pkg;

    // idle cycles before change is paid back on its own
    localparam int K_WAIT_TIME = 10;
    // decoded cycles the return request has to stay high
    localparam int K_TRIGGER_HOLD = 3;

    localparam int K_WAIT_BITS = $clog2(K_WAIT_TIME + 1);
    localparam int K_HOLD_BITS = $clog2(K_TRIGGER_HOLD + 1);

    typedef logic [K_WAIT_BITS-1:0] wait_cnt_t;
    typedef logic [K_HOLD_BITS-1:0] hold_cnt_t;

    // one event per decoded cycle, coin first
    typedef enum logic [1:0] {
        EV_NONE,
        EV_COIN,
        EV_SELECT,
        EV_TRIGGER
    } vm_event_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_RETURN
    } ret_state_e;

endpackage

// ==== rtl/vm_dispense.sv ====
`timescale 1ns/1ps

module vm_dispense
    import vm_money_pkg::*;
    import vm_ctrl_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_reset,
    input  vm_event_e  i_event,
    input  item_idx_t  i_select_idx,
    input  total_t     i_total,
    output item_mask_t o_available_item,
    output logic       o_vend_valid,
    output total_t     o_vend_price,
    output item_mask_t o_output_item
);

    item_mask_t avail;

    // an item can be bought once the balance covers its price
    always_comb begin
        for (int j = 0; j < K_NUM_ITEMS; j++) begin
            avail[j] = (i_total >= K_ITEM_PRICE[j]);
        end
    end

    assign o_available_item = avail;

    // the only place where a selection turns into a vend
    always_comb begin
        o_vend_valid = 1'b0;
        o_vend_price = '0;
        for (int j = 0; j < K_NUM_ITEMS; j++) begin
            if (i_event == EV_SELECT && i_select_idx == item_idx_t'(j) && avail[j]) begin
                o_vend_valid = 1'b1;
                o_vend_price = K_ITEM_PRICE[j];
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_output_item <= '0;
        end else if (o_vend_valid) begin
            o_output_item <= item_mask_t'(1) << i_select_idx;
        end else begin
            o_output_item <= '0;
        end
    end

    a_vend_onehot: assert property (
        @(posedge i_clk) disable iff (i_reset)
        $onehot0(o_output_item)
    );

endmodule

// ==== rtl/vm_event_decode.sv ====
`timescale 1ns/1ps

module vm_event_decode
    import vm_money_pkg::*;
    import vm_ctrl_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_reset,
    input  coin_mask_t i_input_coin,
    input  item_mask_t i_select_item,
    input  logic       i_trigger_return,
    output vm_event_e  o_event,
    output total_t     o_coin_sum,
    output item_idx_t  o_select_idx,
    output logic       o_trigger_level
);

    vm_event_e event_nxt;
    item_idx_t select_nxt;
    total_t    coin_sum_nxt;

    // several coins in one cycle are summed together
    assign coin_sum_nxt = coin_mask_value(i_input_coin);

    // lowest set select bit wins, so scan from the top down
    always_comb begin
        select_nxt = K_SEL_NONE;
        for (int j = K_NUM_ITEMS - 1; j >= 0; j--) begin
            if (i_select_item[j]) begin
                select_nxt = item_idx_t'(j);
            end
        end
    end

    always_comb begin
        if (i_input_coin != '0) begin
            event_nxt = EV_COIN;
        end else if (i_select_item != '0) begin
            event_nxt = EV_SELECT;
        end else if (i_trigger_return) begin
            event_nxt = EV_TRIGGER;
        end else begin
            event_nxt = EV_NONE;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_event         <= EV_NONE;
            o_trigger_level <= 1'b0;
        end else begin
            o_event         <= event_nxt;
            o_trigger_level <= i_trigger_return;
        end
    end

    // payload only, qualified by o_event downstream
    always_ff @(posedge i_clk) begin
        o_coin_sum   <= coin_sum_nxt;
        o_select_idx <= select_nxt;
    end

    // a select event always carries a real item index
    a_select_idx_valid: assert property (
        @(posedge i_clk) disable iff (i_reset)
        (o_event == EV_SELECT) |-> (o_select_idx < item_idx_t'(K_NUM_ITEMS))
    );

endmodule

// ==== rtl/vm_money_pkg.sv ====
package vm_money_pkg;

    // coin set and item table for this machine
    localparam int K_NUM_COINS = 3;
    localparam int K_NUM_ITEMS = 4;
    localparam int K_TOTAL_BITS = 16;

    // one extra code beyond the last item means no selection
    localparam int K_SEL_BITS = $clog2(K_NUM_ITEMS + 1);

    typedef logic [K_NUM_COINS-1:0] coin_mask_t;
    typedef logic [K_NUM_ITEMS-1:0] item_mask_t;
    typedef logic [K_TOTAL_BITS-1:0] total_t;
    typedef logic [K_SEL_BITS-1:0] item_idx_t;

    localparam item_idx_t K_SEL_NONE = item_idx_t'(K_NUM_ITEMS);

    // index 0 is the smallest coin
    localparam total_t K_COIN_VALUE [K_NUM_COINS] = '{
        16'd100, 16'd500, 16'd1000
    };

    localparam total_t K_ITEM_PRICE [K_NUM_ITEMS] = '{
        16'd400, 16'd500, 16'd1000, 16'd2000
    };

    // money value of every coin set in a mask
    function automatic total_t coin_mask_value(coin_mask_t mask);
        total_t sum;
        sum = '0;
        for (int i = 0; i < K_NUM_COINS; i++) begin
            if (mask[i]) begin
                sum = sum + K_COIN_VALUE[i];
            end
        end
        return sum;
    endfunction

endpackage

// ==== rtl/vm_return_timer.sv ====
`timescale 1ns/1ps

module vm_return_timer
    import vm_money_pkg::*;
    import vm_ctrl_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_reset,
    input  vm_event_e  i_event,
    input  logic       i_trigger_level,
    input  logic       i_vend_valid,
    input  total_t     i_total,
    output coin_mask_t o_return_coin,
    output coin_mask_t o_ret_mask
);

    ret_state_e r_state;
    wait_cnt_t  r_wait_cnt;
    hold_cnt_t  r_hold_cnt;
    coin_mask_t greedy;
    logic       trigger_hit;
    logic       activity;

    // a coin or a successful vend counts as customer activity
    assign activity = (i_event == EV_COIN) || i_vend_valid;

    // consecutive decoded cycles with the return request high
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            r_hold_cnt <= '0;
        end else if (!i_trigger_level) begin
            r_hold_cnt <= '0;
        end else if (r_hold_cnt != hold_cnt_t'(K_TRIGGER_HOLD)) begin
            r_hold_cnt <= r_hold_cnt + 1'b1;
        end
    end

    assign trigger_hit = i_trigger_level
                       && (r_hold_cnt >= hold_cnt_t'(K_TRIGGER_HOLD - 1));

    // largest coin first, at most one of each per cycle
    always_comb begin
        total_t remain;
        remain = i_total;
        greedy = '0;
        for (int i = K_NUM_COINS - 1; i >= 0; i--) begin
            if (remain >= K_COIN_VALUE[i]) begin
                greedy[i] = 1'b1;
                remain = remain - K_COIN_VALUE[i];
            end
        end
    end

    // no payout in the cycle a coin or a vend moves the balance
    assign o_ret_mask = (r_state == ST_RETURN && !activity) ? greedy : '0;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            r_state    <= ST_IDLE;
            r_wait_cnt <= wait_cnt_t'(K_WAIT_TIME);
        end else begin
            case (r_state)
                ST_IDLE: begin
                    if (i_event == EV_COIN) begin
                        r_state    <= ST_WAIT;
                        r_wait_cnt <= wait_cnt_t'(K_WAIT_TIME);
                    end
                end
                ST_WAIT: begin
                    if (activity) begin
                        r_wait_cnt <= wait_cnt_t'(K_WAIT_TIME);
                    end else if (i_total == '0) begin
                        // last vend used up the balance
                        r_state <= ST_IDLE;
                    end else if (trigger_hit || r_wait_cnt == '0) begin
                        r_state <= ST_RETURN;
                    end else begin
                        r_wait_cnt <= r_wait_cnt - 1'b1;
                    end
                end
                ST_RETURN: begin
                    if (i_event == EV_COIN) begin
                        r_state    <= ST_WAIT;
                        r_wait_cnt <= wait_cnt_t'(K_WAIT_TIME);
                    end else if (i_total == '0) begin
                        r_state <= ST_IDLE;
                    end
                end
                default: begin
                    r_state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_return_coin <= '0;
        end else begin
            o_return_coin <= o_ret_mask;
        end
    end

    // a pulse is only seen while the state machine is still paying out
    a_return_in_state: assert property (
        @(posedge i_clk) disable iff (i_reset)
        (o_return_coin != '0) |-> ($past(r_state) == ST_RETURN && r_state == ST_RETURN)
    );

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f verilog.f --top-module vm_tb -o vm_tb_sim
out=$(./obj_dir/vm_tb_sim)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Simulation passed"

// ==== verilog.f ====
+incdir+dv
rtl/vm_money_pkg.sv
rtl/vm_ctrl_pkg.sv
rtl/vm_event_decode.sv
rtl/vm_balance.sv
rtl/vm_dispense.sv
rtl/vm_return_timer.sv
rtl/vending_machine.sv
dv/vm_tb.sv
